// ==== hdl/mips_pkg.sv ====
// mips pipeline definitions
`default_nettype none

package mips_pkg;

        localparam int XLEN       = 32;
        localparam int REG_ADDR_W = 5;

        typedef logic [XLEN-1:0]       word_t;
        typedef logic [REG_ADDR_W-1:0] reg_addr_t;

        // primary opcode field
        typedef enum logic [5:0] {
                OP_SPECIAL = 6'h00,
                OP_BEQ     = 6'h04,
                OP_BNE     = 6'h05,
                OP_ADDIU   = 6'h09,
                OP_ORI     = 6'h0d,
                OP_LUI     = 6'h0f,
                OP_LW      = 6'h23,
                OP_SW      = 6'h2b
        } opcode_e;

        // r-type function field
        typedef enum logic [5:0] {
                FN_ADDU = 6'h21,
                FN_SUBU = 6'h23,
                FN_AND  = 6'h24,
                FN_OR   = 6'h25,
                FN_XOR  = 6'h26,
                FN_SLT  = 6'h2a
        } funct_e;

        typedef enum logic [3:0] {
                ALU_NOP,
                ALU_ADD,
                ALU_SUB,
                ALU_AND,
                ALU_OR,
                ALU_XOR,
                ALU_SLT,
                ALU_LUI,
                ALU_LOAD,
                ALU_STORE
        } alu_op_e;

        typedef struct packed {
                logic      we;
                reg_addr_t waddr;
                word_t     wdata;
        } wb_t;

        typedef struct packed {
                alu_op_e   alu_op;
                word_t     op_a;
                word_t     op_b;
                word_t     store_data;
                logic      we;
                reg_addr_t waddr;
                word_t     pc;
        } id_ex_t;

        typedef struct packed {
                logic      is_load;
                logic      is_store;
                word_t     result;
                word_t     store_data;
                logic      we;
                reg_addr_t waddr;
                word_t     pc;
        } ex_mem_t;

        typedef struct packed {
                wb_t   wb;
                word_t pc;
        } mem_wb_t;

endpackage

`default_nettype wire

// ==== hdl/if_stage.sv ====
// instruction fetch stage
`default_nettype none

module if_stage #(
        parameter mips_pkg::word_t RESET_PC = '0
) (
        input  wire logic            clk,
        input  wire logic            rst_n_i,
        input  wire logic            stall_i,
        input  wire logic            branch_taken_i,
        input  wire mips_pkg::word_t branch_target_i,
        input  wire mips_pkg::word_t inst_i,
        output mips_pkg::word_t      pc_o,
        output logic                 fetch_en_o,
        output mips_pkg::word_t      id_pc_o,
        output mips_pkg::word_t      id_inst_o
);

        mips_pkg::word_t pc_q;
        logic            fetch_en_q;

        always_ff @(posedge clk)
        begin
                if (!rst_n_i)
                begin
                        pc_q       <= RESET_PC;
                        fetch_en_q <= 1'b0;
                        id_inst_o  <= '0;
                end
                else
                begin
                        fetch_en_q <= 1'b1;
                        // pc holds until the first fetch has been issued
                        if (fetch_en_q && !stall_i)
                                pc_q <= branch_taken_i ? branch_target_i : pc_q + 32'd4;
                        if (!stall_i)
                        begin
                                id_pc_o   <= pc_q;
                                id_inst_o <= fetch_en_q ? inst_i : '0;
                        end
                end
        end

        assign pc_o       = pc_q;
        assign fetch_en_o = fetch_en_q;

        fetch_after_reset: assert property (@(posedge clk) rst_n_i |=> fetch_en_o);

endmodule

`default_nettype wire

// ==== hdl/id_stage.sv ====
// instruction decode stage
`default_nettype none

module id_stage (
        input  wire logic                clk,
        input  wire logic                rst_n_i,
        input  wire mips_pkg::word_t     pc_i,
        input  wire mips_pkg::word_t     inst_i,
        input  wire mips_pkg::word_t     rdata1_i,
        input  wire mips_pkg::word_t     rdata2_i,
        input  wire mips_pkg::wb_t       ex_fwd_i,
        input  wire logic                ex_is_load_i,
        input  wire mips_pkg::wb_t       mem_fwd_i,
        output mips_pkg::reg_addr_t      raddr1_o,
        output mips_pkg::reg_addr_t      raddr2_o,
        output logic                     stall_o,
        output logic                     branch_taken_o,
        output mips_pkg::word_t          branch_target_o,
        output mips_pkg::id_ex_t         id_ex_o
);

        mips_pkg::opcode_e   opcode;
        mips_pkg::funct_e    funct;
        mips_pkg::reg_addr_t rs;
        mips_pkg::reg_addr_t rt;
        mips_pkg::reg_addr_t rd;
        mips_pkg::word_t     imm_sext;
        mips_pkg::word_t     imm_zext;
        mips_pkg::word_t     rs_val;
        mips_pkg::word_t     rt_val;
        logic                uses_rs;
        logic                uses_rt;
        logic                is_beq;
        logic                is_bne;
        logic                load_use;
        mips_pkg::id_ex_t    id_ex_d;

        // newest producer wins, r0 is never forwarded
        function automatic mips_pkg::word_t fwd(input mips_pkg::reg_addr_t addr,
                                                input mips_pkg::word_t rf_val,
                                                input mips_pkg::wb_t ex_wb,
                                                input mips_pkg::wb_t mem_wb);
                if (addr == '0)
                        return rf_val;
                if (ex_wb.we && ex_wb.waddr == addr)
                        return ex_wb.wdata;
                if (mem_wb.we && mem_wb.waddr == addr)
                        return mem_wb.wdata;
                return rf_val;
        endfunction

        assign opcode   = mips_pkg::opcode_e'(inst_i[31:26]);
        assign funct    = mips_pkg::funct_e'(inst_i[5:0]);
        assign rs       = inst_i[25:21];
        assign rt       = inst_i[20:16];
        assign rd       = inst_i[15:11];
        assign imm_sext = {{16{inst_i[15]}}, inst_i[15:0]};
        assign imm_zext = {16'd0, inst_i[15:0]};

        assign raddr1_o = rs;
        assign raddr2_o = rt;
        assign rs_val   = fwd(rs, rdata1_i, ex_fwd_i, mem_fwd_i);
        assign rt_val   = fwd(rt, rdata2_i, ex_fwd_i, mem_fwd_i);

        always_comb
        begin
                id_ex_d            = '0;
                id_ex_d.alu_op     = mips_pkg::ALU_NOP;
                id_ex_d.op_a       = rs_val;
                id_ex_d.op_b       = imm_sext;
                id_ex_d.store_data = rt_val;
                id_ex_d.waddr      = rt;
                id_ex_d.pc         = pc_i;
                uses_rs            = 1'b0;
                uses_rt            = 1'b0;
                is_beq             = 1'b0;
                is_bne             = 1'b0;
                case (opcode)
                mips_pkg::OP_SPECIAL:
                begin
                        uses_rs       = 1'b1;
                        uses_rt       = 1'b1;
                        id_ex_d.op_b  = rt_val;
                        id_ex_d.waddr = rd;
                        case (funct)
                        mips_pkg::FN_ADDU: id_ex_d.alu_op = mips_pkg::ALU_ADD;
                        mips_pkg::FN_SUBU: id_ex_d.alu_op = mips_pkg::ALU_SUB;
                        mips_pkg::FN_AND:  id_ex_d.alu_op = mips_pkg::ALU_AND;
                        mips_pkg::FN_OR:   id_ex_d.alu_op = mips_pkg::ALU_OR;
                        mips_pkg::FN_XOR:  id_ex_d.alu_op = mips_pkg::ALU_XOR;
                        mips_pkg::FN_SLT:  id_ex_d.alu_op = mips_pkg::ALU_SLT;
                        default:           id_ex_d.alu_op = mips_pkg::ALU_NOP;
                        endcase
                end
                mips_pkg::OP_ADDIU:
                begin
                        uses_rs        = 1'b1;
                        id_ex_d.alu_op = mips_pkg::ALU_ADD;
                end
                mips_pkg::OP_ORI:
                begin
                        uses_rs        = 1'b1;
                        id_ex_d.op_b   = imm_zext;
                        id_ex_d.alu_op = mips_pkg::ALU_OR;
                end
                mips_pkg::OP_LUI:
                begin
                        id_ex_d.op_b   = imm_zext;
                        id_ex_d.alu_op = mips_pkg::ALU_LUI;
                end
                mips_pkg::OP_LW:
                begin
                        uses_rs        = 1'b1;
                        id_ex_d.alu_op = mips_pkg::ALU_LOAD;
                end
                mips_pkg::OP_SW:
                begin
                        uses_rs        = 1'b1;
                        uses_rt        = 1'b1;
                        id_ex_d.alu_op = mips_pkg::ALU_STORE;
                end
                mips_pkg::OP_BEQ,
                mips_pkg::OP_BNE:
                begin
                        uses_rs = 1'b1;
                        uses_rt = 1'b1;
                        is_beq  = (opcode == mips_pkg::OP_BEQ);
                        is_bne  = (opcode == mips_pkg::OP_BNE);
                end
                default:
                        id_ex_d.alu_op = mips_pkg::ALU_NOP;
                endcase
                id_ex_d.we = (id_ex_d.alu_op != mips_pkg::ALU_NOP) &&
                             (id_ex_d.alu_op != mips_pkg::ALU_STORE);
        end

        // load in ex feeding this instruction
        assign load_use = ex_is_load_i && ex_fwd_i.waddr != '0 &&
                          ((uses_rs && ex_fwd_i.waddr == rs) ||
                           (uses_rt && ex_fwd_i.waddr == rt));
        assign stall_o  = load_use;

        // target is relative to the delay slot
        assign branch_target_o = pc_i + 32'd4 + {imm_sext[29:0], 2'b00};
        assign branch_taken_o  = !load_use &&
                                 ((is_beq && rs_val == rt_val) ||
                                  (is_bne && rs_val != rt_val));

        always_ff @(posedge clk)
        begin
                id_ex_o <= id_ex_d;
                if (!rst_n_i || load_use)
                begin
                        id_ex_o.alu_op <= mips_pkg::ALU_NOP;
                        id_ex_o.we     <= 1'b0;
                end
        end

        stall_one_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
                stall_o |=> !stall_o);

endmodule

`default_nettype wire

// ==== hdl/regfile.sv ====
// general purpose register file
`default_nettype none

module regfile (
        input  wire logic                clk,
        input  wire logic                rst_n_i,
        input  wire mips_pkg::reg_addr_t raddr1_i,
        input  wire mips_pkg::reg_addr_t raddr2_i,
        input  wire mips_pkg::wb_t       wr_i,
        output mips_pkg::word_t          rdata1_o,
        output mips_pkg::word_t          rdata2_o
);

        mips_pkg::word_t regs [32];

        always_ff @(posedge clk)
        begin
                if (!rst_n_i)
                        regs <= '{default: '0};
                else if (wr_i.we && wr_i.waddr != '0)
                        regs[wr_i.waddr] <= wr_i.wdata;
        end

        // r0 reads zero, then write-through, then the array
        function automatic mips_pkg::word_t read_port(input mips_pkg::reg_addr_t addr,
                                                      input mips_pkg::wb_t wr,
                                                      input mips_pkg::word_t stored);
                if (addr == '0)
                        return '0;
                if (wr.we && wr.waddr == addr)
                        return wr.wdata;
                return stored;
        endfunction

        assign rdata1_o = read_port(raddr1_i, wr_i, regs[raddr1_i]);
        assign rdata2_o = read_port(raddr2_i, wr_i, regs[raddr2_i]);

endmodule

`default_nettype wire

// ==== hdl/ex_stage.sv ====
// execute stage
`default_nettype none

module ex_stage (
        input  wire logic             clk,
        input  wire logic             rst_n_i,
        input  wire mips_pkg::id_ex_t id_ex_i,
        output mips_pkg::wb_t         ex_fwd_o,
        output logic                  ex_is_load_o,
        output mips_pkg::ex_mem_t     ex_mem_o
);

        mips_pkg::word_t   alu_result;
        mips_pkg::ex_mem_t ex_mem_d;

        always_comb
        begin
                case (id_ex_i.alu_op)
                mips_pkg::ALU_ADD,
                mips_pkg::ALU_LOAD,
                mips_pkg::ALU_STORE:
                        alu_result = id_ex_i.op_a + id_ex_i.op_b;
                mips_pkg::ALU_SUB:
                        alu_result = id_ex_i.op_a - id_ex_i.op_b;
                mips_pkg::ALU_AND:
                        alu_result = id_ex_i.op_a & id_ex_i.op_b;
                mips_pkg::ALU_OR:
                        alu_result = id_ex_i.op_a | id_ex_i.op_b;
                mips_pkg::ALU_XOR:
                        alu_result = id_ex_i.op_a ^ id_ex_i.op_b;
                mips_pkg::ALU_SLT:
                        alu_result = mips_pkg::word_t'($signed(id_ex_i.op_a) <
                                                       $signed(id_ex_i.op_b));
                mips_pkg::ALU_LUI:
                        alu_result = {id_ex_i.op_b[15:0], 16'd0};
                default:
                        alu_result = '0;
                endcase
        end

        // a load result here is only an address, id stalls on it
        assign ex_fwd_o.we    = id_ex_i.we;
        assign ex_fwd_o.waddr = id_ex_i.waddr;
        assign ex_fwd_o.wdata = alu_result;
        assign ex_is_load_o   = (id_ex_i.alu_op == mips_pkg::ALU_LOAD);

        assign ex_mem_d.is_load    = ex_is_load_o;
        assign ex_mem_d.is_store   = (id_ex_i.alu_op == mips_pkg::ALU_STORE);
        assign ex_mem_d.result     = alu_result;
        assign ex_mem_d.store_data = id_ex_i.store_data;
        assign ex_mem_d.we         = id_ex_i.we;
        assign ex_mem_d.waddr      = id_ex_i.waddr;
        assign ex_mem_d.pc         = id_ex_i.pc;

        always_ff @(posedge clk)
        begin
                ex_mem_o <= ex_mem_d;
                if (!rst_n_i)
                begin
                        ex_mem_o.is_load  <= 1'b0;
                        ex_mem_o.is_store <= 1'b0;
                        ex_mem_o.we       <= 1'b0;
                end
        end

endmodule

`default_nettype wire

// ==== hdl/mem_stage.sv ====
// memory access stage
`default_nettype none

module mem_stage (
        input  wire logic              clk,
        input  wire logic              rst_n_i,
        input  wire mips_pkg::ex_mem_t ex_mem_i,
        input  wire mips_pkg::word_t   ram_data_i,
        output logic                   ram_ce_o,
        output logic                   ram_we_o,
        output mips_pkg::word_t        ram_addr_o,
        output mips_pkg::word_t        ram_data_o,
        output mips_pkg::wb_t          mem_fwd_o,
        output mips_pkg::mem_wb_t      mem_wb_o
);

        mips_pkg::mem_wb_t mem_wb_d;

        // data memory answers in the same cycle
        assign ram_ce_o   = ex_mem_i.is_load || ex_mem_i.is_store;
        assign ram_we_o   = ex_mem_i.is_store;
        assign ram_addr_o = ex_mem_i.result;
        assign ram_data_o = ex_mem_i.store_data;

        assign mem_fwd_o.we    = ex_mem_i.we;
        assign mem_fwd_o.waddr = ex_mem_i.waddr;
        assign mem_fwd_o.wdata = ex_mem_i.is_load ? ram_data_i : ex_mem_i.result;

        assign mem_wb_d.wb = mem_fwd_o;
        assign mem_wb_d.pc = ex_mem_i.pc;

        always_ff @(posedge clk)
        begin
                mem_wb_o <= mem_wb_d;
                if (!rst_n_i)
                        mem_wb_o.wb.we <= 1'b0;
        end

        // only word accesses exist
        word_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
                ram_ce_o |-> ram_addr_o[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== hdl/mips_core.sv ====
// five-stage mips core
`default_nettype none

module mips_core #(
        parameter mips_pkg::word_t RESET_PC = '0
) (
        input  wire logic                clk,
        input  wire logic                rst_n_i,

        output logic                     rom_ce_o,
        output mips_pkg::word_t          rom_addr_o,
        input  wire mips_pkg::word_t     rom_data_i,

        output logic                     ram_ce_o,
        output logic                     ram_we_o,
        output mips_pkg::word_t          ram_addr_o,
        output mips_pkg::word_t          ram_data_o,
        input  wire mips_pkg::word_t     ram_data_i,

        output mips_pkg::word_t          debug_wb_pc,
        output logic [3:0]               debug_wb_rf_wen,
        output mips_pkg::reg_addr_t      debug_wb_rf_wnum,
        output mips_pkg::word_t          debug_wb_rf_wdata
);

        mips_pkg::word_t     id_pc;
        mips_pkg::word_t     id_inst;
        logic                stall;
        logic                branch_taken;
        mips_pkg::word_t     branch_target;

        mips_pkg::reg_addr_t raddr1;
        mips_pkg::reg_addr_t raddr2;
        mips_pkg::word_t     rdata1;
        mips_pkg::word_t     rdata2;

        mips_pkg::id_ex_t    id_ex;
        mips_pkg::ex_mem_t   ex_mem;
        mips_pkg::wb_t       ex_fwd;
        logic                ex_is_load;
        mips_pkg::wb_t       mem_fwd;
        mips_pkg::mem_wb_t   mem_wb;

        if_stage #(
                .RESET_PC (RESET_PC)
        ) u_if_stage (
                .clk             (clk),
                .rst_n_i         (rst_n_i),
                .stall_i         (stall),
                .branch_taken_i  (branch_taken),
                .branch_target_i (branch_target),
                .inst_i          (rom_data_i),
                .pc_o            (rom_addr_o),
                .fetch_en_o      (rom_ce_o),
                .id_pc_o         (id_pc),
                .id_inst_o       (id_inst)
        );

        id_stage u_id_stage (
                .clk             (clk),
                .rst_n_i         (rst_n_i),
                .pc_i            (id_pc),
                .inst_i          (id_inst),
                .rdata1_i        (rdata1),
                .rdata2_i        (rdata2),
                .ex_fwd_i        (ex_fwd),
                .ex_is_load_i    (ex_is_load),
                .mem_fwd_i       (mem_fwd),
                .raddr1_o        (raddr1),
                .raddr2_o        (raddr2),
                .stall_o         (stall),
                .branch_taken_o  (branch_taken),
                .branch_target_o (branch_target),
                .id_ex_o         (id_ex)
        );

        regfile u_regfile (
                .clk       (clk),
                .rst_n_i   (rst_n_i),
                .raddr1_i  (raddr1),
                .raddr2_i  (raddr2),
                .wr_i      (mem_wb.wb),
                .rdata1_o  (rdata1),
                .rdata2_o  (rdata2)
        );

        ex_stage u_ex_stage (
                .clk          (clk),
                .rst_n_i      (rst_n_i),
                .id_ex_i      (id_ex),
                .ex_fwd_o     (ex_fwd),
                .ex_is_load_o (ex_is_load),
                .ex_mem_o     (ex_mem)
        );

        mem_stage u_mem_stage (
                .clk        (clk),
                .rst_n_i    (rst_n_i),
                .ex_mem_i   (ex_mem),
                .ram_data_i (ram_data_i),
                .ram_ce_o   (ram_ce_o),
                .ram_we_o   (ram_we_o),
                .ram_addr_o (ram_addr_o),
                .ram_data_o (ram_data_o),
                .mem_fwd_o  (mem_fwd),
                .mem_wb_o   (mem_wb)
        );

        // write-back trace
        assign debug_wb_pc       = mem_wb.pc;
        assign debug_wb_rf_wen   = {4{mem_wb.wb.we}};
        assign debug_wb_rf_wnum  = mem_wb.wb.waddr;
        assign debug_wb_rf_wdata = mem_wb.wb.wdata;

endmodule

`default_nettype wire

// ==== testbench/tb_isa_model.svh ====
// mips instruction level model
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

logic [15:0]     lfsr_state = 16'd36;
mips_pkg::word_t model_regs [32];
mips_pkg::word_t model_mem [64];

// fibonacci lfsr x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
function automatic mips_pkg::word_t rand_bits(input int n);
        mips_pkg::word_t v;
        logic            fb;
        int              i;
        v = '0;
        for (i = 0; i < n; i++)
        begin
                fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
                lfsr_state = {lfsr_state[14:0], fb};
                v          = {v[30:0], fb};
        end
        return v;
endfunction

// steps the program in order with the delay slot
function automatic void model_run(input int n_words);
        mips_pkg::word_t   pc;
        mips_pkg::word_t   npc;
        mips_pkg::word_t   inst;
        mips_pkg::word_t   a;
        mips_pkg::word_t   b;
        mips_pkg::word_t   res;
        mips_pkg::word_t   sext;
        mips_pkg::word_t   addr;
        mips_pkg::reg_addr_t dst;
        logic              wr;
        logic              br;
        pc  = '0;
        npc = 32'd4;
        while (pc < (32'(n_words) << 2))
        begin
                inst = prog[pc[9:2]];
                a    = model_regs[inst[25:21]];
                b    = model_regs[inst[20:16]];
                sext = {{16{inst[15]}}, inst[15:0]};
                addr = a + sext;
                dst  = inst[20:16];
                res  = '0;
                wr   = 1'b0;
                br   = 1'b0;
                case (inst[31:26])
                mips_pkg::OP_SPECIAL:
                begin
                        dst = inst[15:11];
                        wr  = 1'b1;
                        case (inst[5:0])
                        mips_pkg::FN_ADDU: res = a + b;
                        mips_pkg::FN_SUBU: res = a - b;
                        mips_pkg::FN_AND:  res = a & b;
                        mips_pkg::FN_OR:   res = a | b;
                        mips_pkg::FN_XOR:  res = a ^ b;
                        mips_pkg::FN_SLT:  res = {31'd0, $signed(a) < $signed(b)};
                        default:           wr = 1'b0;
                        endcase
                end
                mips_pkg::OP_ADDIU: {wr, res} = {1'b1, a + sext};
                mips_pkg::OP_ORI:   {wr, res} = {1'b1, a | {16'd0, inst[15:0]}};
                mips_pkg::OP_LUI:   {wr, res} = {1'b1, inst[15:0], 16'd0};
                mips_pkg::OP_LW:    {wr, res} = {1'b1, model_mem[addr[7:2]]};
                mips_pkg::OP_SW:    model_mem[addr[7:2]] = b;
                mips_pkg::OP_BEQ:   br = (a == b);
                mips_pkg::OP_BNE:   br = (a != b);
                default:            wr = 1'b0;
                endcase
                if (wr)
                begin
                        exp_pc[exp_count]   = pc;
                        exp_num[exp_count]  = dst;
                        exp_data[exp_count] = res;
                        exp_count++;
                        if (dst != '0)
                                model_regs[dst] = res;
                end
                pc  = npc;
                npc = br ? npc + {sext[29:0], 2'b00} : npc + 32'd4;
        end
endfunction

`endif

// ==== testbench/tb_mips_core.sv ====
// mips core testbench
`default_nettype none

module tb_mips_core;
        timeunit 1ns;
        timeprecision 100ps;

        logic                clk;
        logic                rst_n_i;
        logic                rom_ce_o;
        mips_pkg::word_t     rom_addr_o;
        mips_pkg::word_t     rom_data_i;
        logic                ram_ce_o;
        logic                ram_we_o;
        mips_pkg::word_t     ram_addr_o;
        mips_pkg::word_t     ram_data_o;
        mips_pkg::word_t     ram_data_i;
        mips_pkg::word_t     debug_wb_pc;
        logic [3:0]          debug_wb_rf_wen;
        mips_pkg::reg_addr_t debug_wb_rf_wnum;
        mips_pkg::word_t     debug_wb_rf_wdata;

        mips_pkg::word_t     prog [256];
        mips_pkg::word_t     ram [64];
        mips_pkg::word_t     exp_pc [512];
        mips_pkg::reg_addr_t exp_num [512];
        mips_pkg::word_t     exp_data [512];
        int                  exp_count = 0;
        int                  prog_len = 0;
        int                  wb_idx = 0;
        logic                wb_started = 1'b0;
        int                  fetch_cycles = 0;
        int                  wb_errors = 0;
        int                  mem_errors = 0;
        int                  cycles;
        int                  i;

        `include "tb_isa_model.svh"

        mips_core u_mips_core (.*);

        // both memories answer in the same cycle
        assign rom_data_i = (rom_addr_o[31:10] == '0) ? prog[rom_addr_o[9:2]] : '0;
        assign ram_data_i = ram[ram_addr_o[7:2]];

        always @(posedge clk)
        begin
                if (ram_ce_o && ram_we_o)
                        ram[ram_addr_o[7:2]] <= ram_data_o;
        end

        always @(posedge clk)
        begin
                if (rst_n_i && debug_wb_rf_wen[0])
                begin
                        wb_idx     <= wb_idx + 1;
                        wb_started <= 1'b1;
                end
        end

        // first write-back comes four fetch cycles in
        always @(posedge clk)
        begin
                if (rst_n_i && rom_ce_o)
                        fetch_cycles <= fetch_cycles + 1;
        end

        function automatic mips_pkg::word_t enc_r(input logic [5:0] fn, input int rd,
                                                  input int rs, input int rt);
                return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
        endfunction

        function automatic mips_pkg::word_t enc_i(input logic [5:0] op, input int rt,
                                                  input int rs, input logic [15:0] imm);
                return {op, 5'(rs), 5'(rt), imm};
        endfunction

        function automatic void emit(input mips_pkg::word_t w);
                prog[prog_len] = w;
                prog_len++;
        endfunction

        function automatic int rand_reg();
                return int'(rand_bits(3) % 7) + 1;
        endfunction

        function automatic void build_program();
                int ra;
                int rb;
                int rc;
                int re;
                int rn;
                int blk;
                logic [15:0] off;
                for (blk = 0; blk < 6; blk++)
                begin
                        ra = rand_reg();
                        rb = rand_reg();
                        rc = rand_reg();
                        re = rand_reg();
                        emit(enc_i(mips_pkg::OP_LUI, ra, 0, 16'(rand_bits(16))));
                        emit(enc_i(mips_pkg::OP_ORI, rb, ra, 16'(rand_bits(16))));
                        emit(enc_r(mips_pkg::FN_ADDU, rc, rb, ra));
                        emit(enc_r(mips_pkg::FN_SUBU, re, rc, rb));
                        emit(enc_r(mips_pkg::FN_AND, rand_reg(), re, rc));
                        emit(enc_r(mips_pkg::FN_OR, rand_reg(), rand_reg(), rand_reg()));
                        emit(enc_r(mips_pkg::FN_XOR, rand_reg(), rand_reg(), rand_reg()));
                        emit(enc_r(mips_pkg::FN_SLT, rand_reg(), re, rc));
                        // r0 written, then read as an operand
                        emit(enc_i(mips_pkg::OP_ADDIU, 0, ra, 16'(rand_bits(16))));
                        emit(enc_r(mips_pkg::FN_ADDU, rand_reg(), 0, rb));
                        off = {8'd0, 6'(rand_bits(6)), 2'b00};
                        emit(enc_i(mips_pkg::OP_SW, rc, 0, off));
                        emit(enc_i(mips_pkg::OP_LW, re, 0, off));
                        emit(enc_r(mips_pkg::FN_ADDU, rand_reg(), re, re));
                        // taken, delay slot, two skipped
                        emit(enc_i(mips_pkg::OP_BEQ, 0, 0, 16'd3));
                        emit(enc_i(mips_pkg::OP_ADDIU, rand_reg(), ra, 16'd1));
                        emit(enc_i(mips_pkg::OP_ADDIU, rand_reg(), ra, 16'd2));
                        emit(enc_i(mips_pkg::OP_ADDIU, rand_reg(), ra, 16'd3));
                        emit(enc_i(mips_pkg::OP_BNE, 0, 0, 16'd1));
                        emit(enc_i(mips_pkg::OP_ADDIU, rand_reg(), rb, 16'd4));
                        rn = rand_reg();
                        emit(enc_i(mips_pkg::OP_ORI, rn, 0, 16'd5));
                        // even blocks take bne, odd blocks fall through beq
                        emit(enc_i(blk[0] ? mips_pkg::OP_BEQ : mips_pkg::OP_BNE, 0, rn, 16'd2));
                        emit(enc_i(mips_pkg::OP_ADDIU, rand_reg(), rc, 16'd6));
                        emit(enc_i(mips_pkg::OP_ADDIU, rand_reg(), rc, 16'd7));
                        emit(enc_i(mips_pkg::OP_ADDIU, rand_reg(), rc, 16'd8));
                end
        endfunction

        wb_match: assert property (@(posedge clk) disable iff (!rst_n_i)
                debug_wb_rf_wen[0] |-> (wb_idx < exp_count && debug_wb_pc == exp_pc[wb_idx] &&
                debug_wb_rf_wnum == exp_num[wb_idx] && debug_wb_rf_wdata == exp_data[wb_idx]))
        else
        begin
                wb_errors++;
                $display("** Error wb_match: expected pc=%h r%0d=%h, actual pc=%h r%0d=%h",
                         exp_pc[$sampled(wb_idx)], exp_num[$sampled(wb_idx)],
                         exp_data[$sampled(wb_idx)], $sampled(debug_wb_pc),
                         $sampled(debug_wb_rf_wnum), $sampled(debug_wb_rf_wdata));
        end

        idle_after_reset: assert property (@(posedge clk) disable iff (!rst_n_i)
                !wb_started |-> (!ram_ce_o && !ram_we_o &&
                (debug_wb_rf_wen == 4'h0 || fetch_cycles == 4)))
        else
        begin
                wb_errors++;
                $display("bus activity seen before the first write-back");
        end

        fetch_enable: assert property (@(posedge clk) disable iff (!rst_n_i)
                rom_ce_o == $past(rst_n_i))
        else
        begin
                wb_errors++;
                $display("** Error fetch_enable: expected %b actual %b",
                         !$sampled(rom_ce_o), $sampled(rom_ce_o));
        end

        wen_lanes: assert property (@(posedge clk) disable iff (!rst_n_i)
                debug_wb_rf_wen == 4'h0 || debug_wb_rf_wen == 4'hf)
        else
        begin
                wb_errors++;
                $display("write enable lanes differ from each other");
        end

        initial
        begin
                clk = 1'b0;
                forever #4 clk = ~clk;
        end

        initial
        begin
                rst_n_i = 1'b0;
                for (i = 0; i < 256; i++)
                        prog[i] = '0;
                for (i = 0; i < 32; i++)
                        model_regs[i] = '0;
                // fill pattern over the whole word index
                for (i = 0; i < 64; i++)
                begin
                        ram[i]       = 32'h13579bdf ^ (32'(i) * 32'h01010101);
                        model_mem[i] = 32'h13579bdf ^ (32'(i) * 32'h01010101);
                end
                build_program();
                model_run(prog_len);
                repeat (4) @(posedge clk);
                #1 rst_n_i = 1'b1;
                cycles = 0;
                while (wb_idx < exp_count && cycles < 2000)
                begin
                        @(posedge clk);
                        cycles++;
                end
                if (wb_idx < exp_count)
                begin
                        $display("timeout after %0d cycles, %0d of %0d write-backs seen",
                                 cycles, wb_idx, exp_count);
                        $display("errors: %0d write-back, %0d memory, 1 timeout",
                                 wb_errors, mem_errors);
                        $display("Testbench failed");
                        $finish;
                end
                else
                begin
                        // drain so a stray late write-back is caught
                        repeat (12) @(posedge clk);
                        for (i = 0; i < 64; i++)
                        begin
                                mem_final: assert (ram[i] == model_mem[i])
                                else
                                begin
                                        mem_errors++;
                                        $display("** Error mem_final: word %0d expected %h actual %h",
                                                 i, model_mem[i], ram[i]);
                                end
                        end
                        $display("errors: %0d write-back, %0d memory, 0 timeout",
                                 wb_errors, mem_errors);
                        if (wb_errors == 0 && mem_errors == 0)
                                $display("Testbench passed");
                        else
                                $display("Testbench failed");
                        $finish;
                end
        end

endmodule

`default_nettype wire

// ==== mips_core.f ====
hdl/mips_pkg.sv
hdl/if_stage.sv
hdl/id_stage.sv
hdl/regfile.sv
hdl/ex_stage.sv
hdl/mem_stage.sv
hdl/mips_core.sv
+incdir+testbench
testbench/tb_mips_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mips_core
FILELIST  ?= mips_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
